//--- uart_rx.f
uart_rx_pkg.sv
uart_cfg_ctrl.sv
uart_rx_sampler.sv
uart_frame_check.sv
uart_rx_fifo.sv
uart_rx_top.sv
tb_clk_gen.sv
uart_rx_tb.sv

//--- uart_rx_tb.sv
// uart receive directed testbench
module uart_rx_tb;

    localparam int par_none = 0;
    localparam int par_even = 1;
    localparam int par_odd = 2;
    localparam int err_none = 0;
    localparam int err_parity = 1;
    localparam int err_stop = 2;
    // frames x 12 bits x baud_div per test, doubled
    localparam int timeout_cycles =
        2 * 12 * (8 * 16 + 5 * 10 + 2 * 10 + 3 * 10 + 7 * 10 + 6 * 12);

    logic                               clk;
    logic                               rst;
    logic                               rx;
    uart_rx_pkg::uart_cfg_t             cfg_in;
    logic                               cfg_write;
    logic                               pause_req;
    logic                               pause_ack;
    uart_rx_pkg::rx_char_t              char_out;
    logic                               char_valid;
    logic                               char_ready;
    logic [uart_rx_pkg::baud_div_w-1:0] parity_errors;
    logic [uart_rx_pkg::baud_div_w-1:0] frame_errors;

    uart_rx_pkg::rx_char_t rx_q[$];
    integer seed = 98;
    int     line_baud = 16;
    int     errors = 0;
    int     checks = 0;
    int     tests = 0;
    int     cycles = 0;
    int     exp_parity_errs = 0;
    int     exp_frame_errs = 0;

    tb_clk_gen u_clk_gen (
        .clk (clk),
        .rst (rst)
    );

    uart_rx_top i_dut (
        .clk           (clk),
        .rst           (rst),
        .rx            (rx),
        .cfg_in        (cfg_in),
        .cfg_write     (cfg_write),
        .pause_req     (pause_req),
        .pause_ack     (pause_ack),
        .char_out      (char_out),
        .char_valid    (char_valid),
        .char_ready    (char_ready),
        .parity_errors (parity_errors),
        .frame_errors  (frame_errors)
    );

    // collect every character taken off the output stream
    always @(posedge clk) begin
        if (!rst && char_valid && char_ready) begin
            rx_q.push_back(char_out);
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= timeout_cycles) begin
            $display("run stopped by timeout after %0d cycles", cycles);
            $display("TB FAILED");
            $finish;
        end
    end

    function automatic logic [7:0] rand_byte();
        logic [31:0] r;
        r = $random(seed);
        return r[7:0];
    endfunction

    function automatic uart_rx_pkg::uart_cfg_t make_cfg(input int baud, input int len,
                                                       input logic par_en, input logic odd,
                                                       input logic two);
        uart_rx_pkg::uart_cfg_t c;
        c.baud_div = 16'(baud);
        c.data_len = 4'(len);
        c.parity_en = par_en;
        c.parity_odd = odd;
        c.two_stop = two;
        return c;
    endfunction

    task automatic check_char(input uart_rx_pkg::rx_char_t got,
                              input uart_rx_pkg::rx_char_t exp);
        checks++;
        if (got !== exp) begin
            $display("error char_out got %h exp %h", got.data, exp.data);
            errors++;
        end
    endtask

    task automatic check_count(input string name,
                               input logic [uart_rx_pkg::baud_div_w-1:0] got,
                               input logic [uart_rx_pkg::baud_div_w-1:0] exp);
        checks++;
        if (got !== exp) begin
            $display("error %s got %h exp %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            $display("error %s got %h exp %h", name, got, exp);
            errors++;
        end
    endtask

    // one bit on the line for a full bit period
    task automatic drive_bit(input logic b);
        @(posedge clk);
        rx <= b;
        repeat (line_baud - 1) @(posedge clk);
    endtask

    task automatic idle_bits(input int n);
        repeat (n) drive_bit(1'b1);
    endtask

    task automatic send_frame(input logic [7:0] data, input int len, input int par_mode,
                              input int force_err, input int stops);
        logic [7:0] d;
        logic       par;
        int         i;
        d = data & ((8'd1 << len) - 8'd1);
        // even parity makes the total count of ones even
        par = ^d;
        if (par_mode == par_odd) begin
            par = ~par;
        end
        if (force_err == err_parity) begin
            par = ~par;
        end
        drive_bit(1'b0);
        for (i = 0; i < len; i++) begin
            drive_bit(d[i]);
        end
        if (par_mode != par_none) begin
            drive_bit(par);
        end
        for (i = 0; i < stops; i++) begin
            drive_bit(!(force_err == err_stop && i == 0));
        end
    endtask

    task automatic expect_char(input logic [7:0] exp);
        uart_rx_pkg::rx_char_t e;
        int                    waited;
        e.data = exp;
        waited = 0;
        while (rx_q.size() == 0 && waited < 24 * line_baud) begin
            @(posedge clk);
            waited++;
        end
        if (rx_q.size() == 0) begin
            $display("no character arrived where %h was expected", exp);
            errors++;
        end else begin
            check_char(rx_q.pop_front(), e);
        end
    endtask

    task automatic expect_nothing(input string what);
        checks++;
        if (rx_q.size() != 0) begin
            $display("unexpected character %h after %s", rx_q[0].data, what);
            errors++;
            rx_q.delete();
        end
    endtask

    task automatic check_counters();
        check_count("parity_errors", parity_errors, 16'(exp_parity_errs));
        check_count("frame_errors", frame_errors, 16'(exp_frame_errs));
    endtask

    task automatic report_test(input string name, input int start_errs);
        tests++;
        if (errors == start_errs) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, errors - start_errs);
        end
    endtask

    // pause, load a configuration, release
    task automatic reconfigure(input uart_rx_pkg::uart_cfg_t new_cfg);
        int waited;
        waited = 0;
        @(posedge clk);
        pause_req <= 1'b1;
        @(posedge clk);
        while (!pause_ack && waited < 100) begin
            @(posedge clk);
            waited++;
        end
        check_bit("pause_ack", pause_ack, 1'b1);
        cfg_in <= new_cfg;
        cfg_write <= 1'b1;
        @(posedge clk);
        cfg_write <= 1'b0;
        pause_req <= 1'b0;
        // ack falls the clock after the request
        repeat (2) @(posedge clk);
        check_bit("pause_ack", pause_ack, 1'b0);
    endtask

    task automatic default_8n1_stream();
        logic [7:0] sent [8];
        int         start_errs;
        int         i;
        start_errs = errors;
        line_baud = 16;
        for (i = 0; i < 8; i++) begin
            sent[i] = rand_byte();
            send_frame(sent[i], 8, par_none, err_none, 1);
            idle_bits(1);
        end
        for (i = 0; i < 8; i++) begin
            expect_char(sent[i]);
        end
        check_counters();
        report_test("default 8N1", start_errs);
    endtask

    task automatic pause_and_reconfigure();
        logic [7:0] d;
        int         start_errs;
        int         i;
        start_errs = errors;
        reconfigure(make_cfg(10, 7, 1'b1, 1'b1, 1'b1));
        line_baud = 10;
        for (i = 0; i < 4; i++) begin
            d = rand_byte();
            send_frame(d, 7, par_odd, err_none, 2);
            idle_bits(1);
            expect_char(d & 8'h7f);
        end
        // write outside a pause must be ignored
        @(posedge clk);
        cfg_in <= make_cfg(16, 8, 1'b0, 1'b0, 1'b0);
        cfg_write <= 1'b1;
        @(posedge clk);
        cfg_write <= 1'b0;
        d = rand_byte();
        send_frame(d, 7, par_odd, err_none, 2);
        idle_bits(1);
        expect_char(d & 8'h7f);
        check_counters();
        report_test("pause and reconfigure", start_errs);
    endtask

    task automatic parity_error_drop();
        logic [7:0] d;
        int         start_errs;
        start_errs = errors;
        send_frame(rand_byte(), 7, par_odd, err_parity, 2);
        idle_bits(2);
        exp_parity_errs++;
        expect_nothing("parity error frame");
        check_counters();
        d = rand_byte();
        send_frame(d, 7, par_odd, err_none, 2);
        idle_bits(1);
        expect_char(d & 8'h7f);
        report_test("parity error", start_errs);
    endtask

    task automatic framing_error_drop();
        logic [7:0] d;
        int         start_errs;
        start_errs = errors;
        send_frame(rand_byte(), 7, par_odd, err_stop, 2);
        idle_bits(2);
        exp_frame_errs++;
        expect_nothing("frame error frame");
        check_counters();
        // low pulse well under half a bit
        @(posedge clk);
        rx <= 1'b0;
        repeat (line_baud / 2 - 2) @(posedge clk);
        rx <= 1'b1;
        idle_bits(2);
        expect_nothing("short glitch");
        check_counters();
        d = rand_byte();
        send_frame(d, 7, par_odd, err_none, 2);
        idle_bits(1);
        expect_char(d & 8'h7f);
        report_test("framing error and glitch", start_errs);
    endtask

    task automatic backpressure_stall();
        logic [7:0] sent [7];
        int         start_errs;
        int         i;
        start_errs = errors;
        @(posedge clk);
        char_ready <= 1'b0;
        // four fill the fifo, then checker, sampler, and one lost
        for (i = 0; i < 7; i++) begin
            sent[i] = rand_byte();
            send_frame(sent[i], 7, par_odd, err_none, 2);
            idle_bits(3);
        end
        // fifo holds data while the reader stalls
        check_bit("char_valid", char_valid, 1'b1);
        @(posedge clk);
        char_ready <= 1'b1;
        for (i = 0; i < 6; i++) begin
            expect_char(sent[i] & 8'h7f);
        end
        idle_bits(14);
        expect_nothing("draining six characters");
        check_counters();
        report_test("back-pressure", start_errs);
    endtask

    task automatic five_bit_even_parity();
        logic [7:0] d;
        int         start_errs;
        int         i;
        start_errs = errors;
        reconfigure(make_cfg(12, 5, 1'b1, 1'b0, 1'b0));
        line_baud = 12;
        for (i = 0; i < 6; i++) begin
            d = rand_byte();
            send_frame(d, 5, par_even, err_none, 1);
            idle_bits(1);
            expect_char(d & 8'h1f);
        end
        check_counters();
        report_test("5E1", start_errs);
    endtask

    initial begin
        rx = 1'b1;
        cfg_in = '0;
        cfg_write = 1'b0;
        pause_req = 1'b0;
        char_ready = 1'b1;
        @(posedge clk);
        while (rst) begin
            @(posedge clk);
        end
        idle_bits(1);

        default_8n1_stream();
        pause_and_reconfigure();
        parity_error_drop();
        framing_error_drop();
        backpressure_stall();
        five_bit_even_parity();

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

//--- tb_clk_gen.sv
// testbench clock and reset
module tb_clk_gen (
    output logic clk,
    output logic rst
);

    localparam int half_period = 2;
    localparam int reset_cycles = 3;

    initial begin
        clk = 1'b0;
        forever begin
            #half_period clk = ~clk;
        end
    end

    // reset held for the first few rising edges
    initial begin
        rst = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

//--- uart_rx_top.sv
// uart receive subsystem
module uart_rx_top (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               rx,
    input  uart_rx_pkg::uart_cfg_t             cfg_in,
    input  logic                               cfg_write,
    input  logic                               pause_req,
    output logic                               pause_ack,
    output uart_rx_pkg::rx_char_t              char_out,
    output logic                               char_valid,
    input  logic                               char_ready,
    output logic [uart_rx_pkg::baud_div_w-1:0] parity_errors,
    output logic [uart_rx_pkg::baud_div_w-1:0] frame_errors
);

    uart_rx_pkg::uart_cfg_t  cfg;
    logic                    paused;
    logic                    sampler_idle;

    // sampler to checker
    uart_rx_pkg::raw_frame_t frame;
    logic                    frame_valid;
    logic                    frame_ready;

    // checker to fifo
    uart_rx_pkg::rx_char_t   push_data;
    logic                    push_valid;
    logic                    push_ready;

    uart_cfg_ctrl u_cfg_ctrl (
        .clk          (clk),
        .rst          (rst),
        .cfg_in       (cfg_in),
        .cfg_write    (cfg_write),
        .pause_req    (pause_req),
        .sampler_idle (sampler_idle),
        .pause_ack    (pause_ack),
        .cfg          (cfg),
        .paused       (paused)
    );

    uart_rx_sampler u_sampler (
        .clk          (clk),
        .rst          (rst),
        .rx           (rx),
        .cfg          (cfg),
        .paused       (paused),
        .sampler_idle (sampler_idle),
        .frame        (frame),
        .frame_valid  (frame_valid),
        .frame_ready  (frame_ready)
    );

    uart_frame_check u_frame_check (
        .clk           (clk),
        .rst           (rst),
        .frame         (frame),
        .frame_valid   (frame_valid),
        .frame_ready   (frame_ready),
        .cfg           (cfg),
        .char_data     (push_data),
        .push_valid    (push_valid),
        .push_ready    (push_ready),
        .parity_errors (parity_errors),
        .frame_errors  (frame_errors)
    );

    uart_rx_fifo u_fifo (
        .clk      (clk),
        .rst      (rst),
        .wr_data  (push_data),
        .wr_valid (push_valid),
        .wr_ready (push_ready),
        .rd_data  (char_out),
        .rd_valid (char_valid),
        .rd_ready (char_ready)
    );

endmodule

//--- uart_rx_fifo.sv
// uart receive character fifo
module uart_rx_fifo (
    input  logic                  clk,
    input  logic                  rst,
    input  uart_rx_pkg::rx_char_t wr_data,
    input  logic                  wr_valid,
    output logic                  wr_ready,
    output uart_rx_pkg::rx_char_t rd_data,
    output logic                  rd_valid,
    input  logic                  rd_ready
);

    uart_rx_pkg::rx_char_t mem [uart_rx_pkg::fifo_depth];

    logic [uart_rx_pkg::fifo_ptr_w-1:0] wr_ptr;
    logic [uart_rx_pkg::fifo_ptr_w-1:0] rd_ptr;
    // one extra bit to tell full from empty
    logic [uart_rx_pkg::fifo_ptr_w:0]   count;
    logic                               do_wr;
    logic                               do_rd;

    assign wr_ready = (count != uart_rx_pkg::fifo_depth);
    assign rd_valid = (count != '0);
    assign rd_data = mem[rd_ptr];

    assign do_wr = wr_valid && wr_ready;
    assign do_rd = rd_valid && rd_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            // pointers wrap on their own at depth 4
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end

            case ({do_wr, do_rd})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // storage
    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_data;
        end
    end

endmodule

//--- uart_frame_check.sv
// uart frame parity and stop check
module uart_frame_check (
    input  logic                                clk,
    input  logic                                rst,
    input  uart_rx_pkg::raw_frame_t             frame,
    input  logic                                frame_valid,
    output logic                                frame_ready,
    input  uart_rx_pkg::uart_cfg_t              cfg,
    output uart_rx_pkg::rx_char_t               char_data,
    output logic                                push_valid,
    input  logic                                push_ready,
    output logic [uart_rx_pkg::baud_div_w-1:0]  parity_errors,
    output logic [uart_rx_pkg::baud_div_w-1:0]  frame_errors
);

    logic accept;
    logic parity_calc;
    logic parity_bad;
    logic stop_bad;

    // output stage empty or draining this clock
    assign frame_ready = !push_valid || push_ready;
    assign accept = frame_valid && frame_ready;

    // unused high data bits are zero, so they drop out of the xor
    assign parity_calc = (^frame.data) ^ cfg.parity_odd;
    assign parity_bad = cfg.parity_en && (frame.parity_bit != parity_calc);
    assign stop_bad = !frame.stop_ok;

    always_ff @(posedge clk) begin
        if (rst) begin
            push_valid    <= 1'b0;
            parity_errors <= '0;
            frame_errors  <= '0;
        end else begin
            if (accept) begin
                // bad frames leave the stage empty
                push_valid <= !stop_bad && !parity_bad;
            end else if (push_ready) begin
                push_valid <= 1'b0;
            end

            // stop error wins over parity error, counters saturate
            if (accept && stop_bad && (frame_errors != '1)) begin
                frame_errors <= frame_errors + 1'b1;
            end
            if (accept && !stop_bad && parity_bad && (parity_errors != '1)) begin
                parity_errors <= parity_errors + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            char_data.data <= frame.data;
        end
    end

endmodule

//--- uart_rx_sampler.sv
// uart receive line sampler
module uart_rx_sampler (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    rx,
    input  uart_rx_pkg::uart_cfg_t  cfg,
    input  logic                    paused,
    output logic                    sampler_idle,
    output uart_rx_pkg::raw_frame_t frame,
    output logic                    frame_valid,
    input  logic                    frame_ready
);

    typedef enum logic [2:0] {
        st_idle,
        st_start,
        st_data,
        st_parity,
        st_stop,
        st_done,
        st_hold
    } state_t;

    state_t                             state;
    logic                               rx_meta;
    logic                               rx_sync;
    logic [uart_rx_pkg::baud_div_w-1:0] cnt;
    logic [3:0]                         bit_cnt;
    logic                               tick;
    logic                               in_bit;

    // mid-bit sample point
    assign tick = (cnt == '0);
    assign in_bit = (state == st_start) || (state == st_data) ||
                    (state == st_parity) || (state == st_stop);

    // idle also requires the line high, so no start is being picked up right now
    assign sampler_idle = (state == st_idle) && rx_sync;
    assign frame_valid = (state == st_hold);

    always_ff @(posedge clk) begin
        if (rst) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            state   <= st_idle;
            cnt     <= '0;
            bit_cnt <= '0;
        end else if (!paused) begin
            rx_meta <= rx;
            rx_sync <= rx_meta;

            // bit-period counter, reloaded at each sample
            if (in_bit) begin
                if (tick) begin
                    cnt <= cfg.baud_div - 1'b1;
                end else begin
                    cnt <= cnt - 1'b1;
                end
            end

            case (state)
                st_idle: begin
                    if (!rx_sync) begin
                        // half a bit to reach the middle of the start bit
                        cnt   <= (cfg.baud_div >> 1) - 1'b1;
                        state <= st_start;
                    end
                end
                st_start: begin
                    if (tick) begin
                        // a high line here was only a glitch
                        if (rx_sync) begin
                            state <= st_idle;
                        end else begin
                            bit_cnt <= '0;
                            state   <= st_data;
                        end
                    end
                end
                st_data: begin
                    if (tick) begin
                        if (bit_cnt == cfg.data_len - 4'd1) begin
                            bit_cnt <= '0;
                            state   <= cfg.parity_en ? st_parity : st_stop;
                        end else begin
                            bit_cnt <= bit_cnt + 4'd1;
                        end
                    end
                end
                st_parity: begin
                    if (tick) begin
                        state <= st_stop;
                    end
                end
                st_stop: begin
                    if (tick) begin
                        if (bit_cnt == {3'b000, cfg.two_stop}) begin
                            state <= st_done;
                        end else begin
                            bit_cnt <= bit_cnt + 4'd1;
                        end
                    end
                end
                st_done: begin
                    state <= st_hold;
                end
                st_hold: begin
                    // no new start search until the frame is taken
                    if (frame_ready) begin
                        state <= st_idle;
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    // frame capture
    always_ff @(posedge clk) begin
        if (!paused && tick) begin
            case (state)
                st_start: begin
                    frame.data       <= '0;
                    frame.parity_bit <= 1'b0;
                    frame.stop_ok    <= 1'b1;
                end
                st_data: begin
                    frame.data[bit_cnt[2:0]] <= rx_sync;
                end
                st_parity: begin
                    frame.parity_bit <= rx_sync;
                end
                st_stop: begin
                    frame.stop_ok <= frame.stop_ok & rx_sync;
                end
                default: begin
                end
            endcase
        end
    end

endmodule

//--- uart_cfg_ctrl.sv
// uart receive configuration and pause control
module uart_cfg_ctrl (
    input  logic                   clk,
    input  logic                   rst,
    input  uart_rx_pkg::uart_cfg_t cfg_in,
    input  logic                   cfg_write,
    input  logic                   pause_req,
    input  logic                   sampler_idle,
    output logic                   pause_ack,
    output uart_rx_pkg::uart_cfg_t cfg,
    output logic                   paused
);

    // frozen only while both halves of the handshake are high
    assign paused = pause_req && pause_ack;

    // acknowledge handshake
    always_ff @(posedge clk) begin
        if (rst) begin
            pause_ack <= 1'b0;
        end else if (!pause_ack) begin
            // grant only between frames
            pause_ack <= pause_req && sampler_idle;
        end else begin
            // drop one clock after the request goes away
            pause_ack <= pause_req;
        end
    end

    // active configuration
    always_ff @(posedge clk) begin
        if (rst) begin
            cfg <= uart_rx_pkg::cfg_default;
        end else if (cfg_write && paused) begin
            cfg <= cfg_in;
        end
    end

endmodule

//--- uart_rx_pkg.sv
// uart receive shared types
package uart_rx_pkg;

    // bit-period count width, also the error counter width
    localparam int baud_div_w = 16;

    // character fifo geometry
    localparam int fifo_depth = 4;
    localparam int fifo_ptr_w = 2;

    // widest character the receiver handles
    localparam int data_w = 8;

    // active receive configuration
    typedef struct packed {
        // clock cycles per bit, at least 4
        logic [baud_div_w-1:0] baud_div;
        // 5 to 8 data bits
        logic [3:0]            data_len;
        logic                  parity_en;
        logic                  parity_odd;
        logic                  two_stop;
    } uart_cfg_t;

    // frame as sampled off the line, before any checking
    typedef struct packed {
        // lsb first, unused high bits zero
        logic [data_w-1:0] data;
        logic              parity_bit;
        // every stop bit sampled high
        logic              stop_ok;
    } raw_frame_t;

    // one received character
    typedef struct packed {
        logic [data_w-1:0] data;
    } rx_char_t;

    // 8N1 at 16 clocks per bit
    localparam uart_cfg_t cfg_default = '{
        baud_div:   16'd16,
        data_len:   4'd8,
        parity_en:  1'b0,
        parity_odd: 1'b0,
        two_stop:   1'b0
    };

endpackage
